/* Bender.yml */
package:
  name: fifo_axis

dependencies: {}

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fifo_axis_pkg.sv
      - source/sync_fifo.sv
      - source/fifo2axis.sv
      - source/fifo_axis_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_fifo_axis.sv

/* filelist.f */
+incdir+source
source/fifo_axis_pkg.sv
source/sync_fifo.sv
source/fifo2axis.sv
source/fifo_axis_top.sv
verif/tb_fifo_axis.sv

/* source/fifo2axis.sv */
`timescale 1ns/1ps
`include "fifo_axis_cfg.svh"

module fifo2axis (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      en_i,
   input  logic [`FA_LEN_W-1:0]      len_i,

   // fifo read port
   input  logic                      fifo_empty_i,
   output logic                      fifo_read_o,
   input  logic [`FA_DATA_W-1:0]     fifo_rdata_i,

   // axi-stream master
   output logic                      axis_tvalid_o,
   output fifo_axis_pkg::axis_beat_t axis_beat_o,
   input  logic                      axis_tready_i
);

   import fifo_axis_pkg::*;

   logic                 read_cond;
   logic                 fifo_read_r;
   logic                 out_en;
   logic                 saved;
   axis_beat_t           saved_beat;
   axis_beat_t           arriving_beat;
   logic [`FA_LEN_W-1:0] len_m1;
   logic [`FA_LEN_W-1:0] word_cnt;

   // pop when the sink moves, or when nothing is
   // held in the saved slot and no pop is in flight
   assign read_cond   = axis_tready_i | ~(saved | fifo_read_r);
   assign fifo_read_o = en_i & ~fifo_empty_i & read_cond;

   // pop in flight, data arrives next cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fifo_read_r <= 1'b0;
      end else begin
         fifo_read_r <= fifo_read_o;
      end
   end

   // word counter, modulo len
   assign len_m1 = len_i - 1'b1;

   // starts at all ones so the first pop lands on index 0
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         word_cnt <= '1;
      end else if (fifo_read_o) begin
         if (word_cnt == len_m1) begin
            word_cnt <= '0;
         end else begin
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

   // counter already points at the popped word when it arrives
   assign arriving_beat.tdata = fifo_rdata_i;
   assign arriving_beat.tlast = (word_cnt == len_m1);

   // output register is free or being emptied this cycle
   assign out_en = ~axis_tvalid_o | axis_tready_i;

   // saved flag
   // set by an arrival the output register cannot take
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         saved <= 1'b0;
      end else if (out_en) begin
         saved <= 1'b0;
      end else if (fifo_read_r) begin
         saved <= 1'b1;
      end
   end

   // saved beat follows every arrival
   // only read while the saved flag is up
   always_ff @(posedge clk_i) begin
      if (fifo_read_r) begin
         saved_beat <= arriving_beat;
      end
   end

   // output valid
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         axis_tvalid_o <= 1'b0;
      end else if (out_en) begin
         axis_tvalid_o <= saved | fifo_read_r;
      end
   end

   // output beat, saved word goes first
   always_ff @(posedge clk_i) begin
      if (out_en) begin
         if (saved) begin
            axis_beat_o <= saved_beat;
         end else begin
            axis_beat_o <= arriving_beat;
         end
      end
   end

endmodule

/* source/fifo_axis_cfg.svh */
`ifndef FIFO_AXIS_CFG_SVH
`define FIFO_AXIS_CFG_SVH

// width of one stream word
`define FA_DATA_W 16

// width of the packet length and of the word counter
`define FA_LEN_W 8

// fifo holds 2**FA_DEPTH_LOG2 words
`define FA_DEPTH_LOG2 3

// the output register and the saved slot
// hold at most two words between fifo and sink,
// on top of what sits in the fifo itself

`endif

/* source/fifo_axis_pkg.sv */
`include "fifo_axis_cfg.svh"

package fifo_axis_pkg;

   // one data word as stored in the fifo
   typedef logic [`FA_DATA_W-1:0] word_t;

   // stream beat without its valid bit
   // tdata sits in the upper bits, tlast in bit 0
   typedef struct packed {
      logic [`FA_DATA_W-1:0] tdata;
      logic                  tlast;
   } axis_beat_t;

   // fifo write side, a plain strobe with data
   // en is high for one cycle per word
   typedef struct packed {
      logic                  en;
      logic [`FA_DATA_W-1:0] data;
   } fifo_wr_t;

   // both structs carry FA_DATA_W+1 bits
   // the valid bit of a beat travels on its own wire
   // so that the output register can gate it alone

endpackage

/* source/fifo_axis_top.sv */
`timescale 1ns/1ps
`include "fifo_axis_cfg.svh"

module fifo_axis_top (
   input  logic                      clk_i,
   input  logic                      rst_n_i,

   // write side
   input  fifo_axis_pkg::fifo_wr_t   wr_i,
   output logic                      full_o,

   // bridge control
   input  logic                      en_i,
   input  logic [`FA_LEN_W-1:0]      len_i,

   // axi-stream master
   output logic                      axis_tvalid_o,
   output fifo_axis_pkg::axis_beat_t axis_beat_o,
   input  logic                      axis_tready_i
);

   import fifo_axis_pkg::*;

   // fifo read port, driven by the bridge
   logic  fifo_read;
   logic  fifo_empty;
   word_t fifo_rdata;

   sync_fifo u_fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .wr_i   (wr_i),
      .full_o (full_o),
      .read_i (fifo_read),
      .empty_o(fifo_empty),
      .rdata_o(fifo_rdata)
   );

   fifo2axis u_bridge (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .en_i         (en_i),
      .len_i        (len_i),
      .fifo_empty_i (fifo_empty),
      .fifo_read_o  (fifo_read),
      .fifo_rdata_i (fifo_rdata),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_beat_o  (axis_beat_o),
      .axis_tready_i(axis_tready_i)
   );

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ps
`include "fifo_axis_cfg.svh"

module sync_fifo (
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   // write side
   input  fifo_axis_pkg::fifo_wr_t wr_i,
   output logic                    full_o,

   // read side
   input  logic                    read_i,
   output logic                    empty_o,
   output logic [`FA_DATA_W-1:0]   rdata_o
);

   import fifo_axis_pkg::*;

   localparam int unsigned ADDR_W = `FA_DEPTH_LOG2;
   localparam int unsigned DEPTH  = 1 << ADDR_W;

   // storage
   word_t           mem [DEPTH];

   // pointers carry one extra wrap bit
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;

   logic            wr_ok;
   logic            rd_ok;

   // writes while full are dropped
   assign wr_ok = wr_i.en & ~full_o;

   // reads while empty are dropped as well
   assign rd_ok = read_i & ~empty_o;

   // same address and same wrap bit means nothing stored
   assign empty_o = (wr_ptr == rd_ptr);

   // same address, wrap bits differ: every entry taken
   assign full_o = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // write pointer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
      end else if (wr_ok) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // read pointer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr <= '0;
      end else if (rd_ok) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // memory write
   always_ff @(posedge clk_i) begin
      if (wr_ok) begin
         mem[wr_ptr[ADDR_W-1:0]] <= wr_i.data;
      end
   end

   // registered read, word shows one cycle after the strobe
   // and holds until the next read
   always_ff @(posedge clk_i) begin
      if (rd_ok) begin
         rdata_o <= mem[rd_ptr[ADDR_W-1:0]];
      end
   end

endmodule

/* verif/tb_fifo_axis.sv */
`timescale 1ns/1ps
`include "fifo_axis_cfg.svh"

module tb_fifo_axis;

   import fifo_axis_pkg::*;

   localparam int DEPTH        = 1 << `FA_DEPTH_LOG2;
   localparam int NUM_ROWS     = 6;
   localparam int RST_CYCLES   = 16;
   localparam int HOLD_CYCLES  = 24;
   localparam int QUIET_CYCLES = 10;

   // tready modes
   localparam logic [1:0] RDY_HIGH = 2'd0;
   localparam logic [1:0] RDY_RAND = 2'd1;
   localparam logic [1:0] RDY_LOW  = 2'd2;

   typedef struct packed {
      logic [7:0] words;
      logic [7:0] len;
      logic       en_low;
      logic [1:0] rdy_mode;
   } row_t;

   logic                 clk;
   logic                 rst_n;
   fifo_wr_t             wr;
   logic                 en;
   logic [`FA_LEN_W-1:0] len;
   logic                 tready;
   logic                 full;
   logic                 tvalid;
   axis_beat_t           beat;

   row_t   rows [NUM_ROWS];
   word_t  exp_q [$];
   integer seed;
   int     errors;
   int     beat_idx;
   int     limit_cycles;
   bit     row_done;

   fifo_axis_top dut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .wr_i         (wr),
      .full_o       (full),
      .en_i         (en),
      .len_i        (len),
      .axis_tvalid_o(tvalid),
      .axis_beat_o  (beat),
      .axis_tready_i(tready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic row_t make_row(input int words, input int len_v, input bit en_low,
                                     input logic [1:0] mode);
      row_t r;
      r.words    = words[7:0];
      r.len      = len_v[7:0];
      r.en_low   = en_low;
      r.rdy_mode = mode;
      return r;
   endfunction

   // row number in the upper nibble, word index below
   function automatic word_t word_of(input int r_idx, input int i);
      return word_t'(r_idx * 4096 + i);
   endfunction

   // last beat of each packet, counted from reset
   function automatic bit tlast_of(input int idx, input int len_v);
      return (idx % len_v) == (len_v - 1);
   endfunction

   task automatic reset_dut(input row_t r);
      @(posedge clk);
      rst_n  <= 1'b0;
      wr     <= '0;
      en     <= 1'b0;
      tready <= 1'b0;
      len    <= r.len;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      en    <= ~r.en_low;
      exp_q.delete();
      beat_idx = 0;
      row_done = 1'b0;
      @(posedge clk);
      assert (!tvalid && !full) else begin
         $display("Error %0t: tvalid or full high after reset", $time);
         errors++;
      end
   endtask

   // a word counts as written at the edge that sees its strobe with full low
   // en-low rows write blindly and only the first DEPTH words can land
   task automatic write_words(input int r_idx, input row_t r);
      int done;
      done = 0;
      wr.en   <= 1'b1;
      wr.data <= word_of(r_idx, 0);
      while (done < r.words) begin
         @(posedge clk);
         if (r.en_low || !full) begin
            if (!r.en_low || done < DEPTH) begin
               exp_q.push_back(word_of(r_idx, done));
            end
            done++;
         end
         if (done < r.words) begin
            wr.en   <= 1'b1;
            wr.data <= word_of(r_idx, done);
         end else begin
            wr <= '0;
         end
      end
      if (r.en_low) begin
         @(posedge clk);
         assert (full) else begin
            $display("Error %0t: full_o low after %0d writes", $time, r.words);
            errors++;
         end
         en <= 1'b1;
      end
   endtask

   task automatic drive_ready(input logic [1:0] mode);
      case (mode)
         RDY_HIGH: tready <= 1'b1;
         RDY_RAND: begin
            while (!row_done) begin
               tready <= $random(seed);
               @(posedge clk);
            end
         end
         default: begin
            // hold the first beat back for a while
            tready <= 1'b0;
            @(posedge clk);
            while (!tvalid) @(posedge clk);
            repeat (HOLD_CYCLES) @(posedge clk);
            tready <= 1'b1;
         end
      endcase
   endtask

   task automatic watch_beats(input int n_exp, input int len_v);
      int         got;
      bit         stalled;
      axis_beat_t held;
      word_t      want;
      got     = 0;
      stalled = 1'b0;
      held    = '0;
      while (got < n_exp) begin
         @(posedge clk);
         if (stalled) begin
            assert (tvalid && beat == held) else begin
               $display("Error %0t: beat dropped or changed while stalled", $time);
               errors++;
            end
         end
         if (!en) begin
            assert (!tvalid) else begin
               $display("Error %0t: tvalid high while en_i low", $time);
               errors++;
            end
         end
         if (tvalid && tready) begin
            assert (exp_q.size() > 0) else begin
               $display("Error %0t: beat %h with no word expected", $time, beat.tdata);
               errors++;
            end
            if (exp_q.size() > 0) begin
               want = exp_q.pop_front();
               assert (beat.tdata == want) else begin
                  $display("Error %0t: tdata %h, expected %h", $time, beat.tdata, want);
                  errors++;
               end
            end
            assert (beat.tlast == tlast_of(beat_idx, len_v)) else begin
               $display("Error %0t: tlast %b on beat %0d", $time, beat.tlast, beat_idx);
               errors++;
            end
            beat_idx++;
            got++;
         end
         stalled = tvalid && !tready;
         held    = beat;
      end
      // nothing may follow the last word
      repeat (QUIET_CYCLES) begin
         @(posedge clk);
         assert (!tvalid) else begin
            $display("Error %0t: extra beat %h after the last word", $time, beat.tdata);
            errors++;
         end
      end
      @(negedge clk);
      row_done = 1'b1;
   endtask

   initial begin
      int total;
      int n_exp;
      int err_before;
      int passed;
      int failed;
      rst_n  = 1'b0;
      wr     = '0;
      en     = 1'b0;
      len    = 1;
      tready = 1'b0;
      seed   = 32'h9a18afa6;
      errors = 0;
      passed = 0;
      failed = 0;
      rows[0] = make_row(20, 4, 1'b0, RDY_HIGH);
      rows[1] = make_row(30, 5, 1'b0, RDY_RAND);
      rows[2] = make_row(25, 1, 1'b0, RDY_RAND);
      rows[3] = make_row(DEPTH + 4, 3, 1'b1, RDY_HIGH);
      rows[4] = make_row(6, 2, 1'b0, RDY_LOW);
      rows[5] = make_row(40, 7, 1'b0, RDY_RAND);
      total = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         total += rows[i].words;
      end
      limit_cycles = total * 20 + NUM_ROWS * RST_CYCLES;
      for (int i = 0; i < NUM_ROWS; i++) begin
         err_before = errors;
         n_exp = (rows[i].en_low && rows[i].words > DEPTH) ? DEPTH : rows[i].words;
         reset_dut(rows[i]);
         fork
            write_words(i, rows[i]);
            drive_ready(rows[i].rdy_mode);
            watch_beats(n_exp, rows[i].len);
         join
         if (errors == err_before) begin
            passed++;
            $display("test %0d: %0d words, len %0d: ok", i, rows[i].words, rows[i].len);
         end else begin
            failed++;
            $display("test %0d: %0d words, len %0d: FAIL with %0d errors", i,
                     rows[i].words, rows[i].len, errors - err_before);
         end
      end
      $display("summary: %0d passed, %0d failing", passed, failed);
      if (failed == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // watchdog, limit comes from the table
   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles, stopping", limit_cycles);
      $display("tests failed");
      $finish;
   end

endmodule
